/* hw/mcu_pkg.sv */
// MCU peripheral definitions
`default_nettype none

package mcu_pkg;

	localparam int data_w = 32; // cpu data word
	localparam int num_timers = 2; // ms timers behind the window
	localparam int timer_idx_w = (num_timers > 1) ? $clog2(num_timers) : 1;
	localparam int presc_w = 20; // ms prescaler width

	// window select, upper address half
	localparam logic [15:0] periph_base = 16'hFFFF;

	// register offsets, lower address half
	localparam logic [15:0] off_slot_id = 16'hFF80;
	localparam logic [15:0] off_slot_bridgeaddr = 16'hFF84;
	localparam logic [15:0] off_slot_length = 16'hFF88;
	localparam logic [15:0] off_slot_offset = 16'hFF8C;
	localparam logic [15:0] off_slot_ctrl = 16'hFF90; // cmd on write, status on read
	localparam logic [15:0] off_ms_ticks = 16'hFF98;
	localparam logic [15:0] off_reset_out = 16'hFFA4;
	localparam logic [15:0] off_update_flag = 16'hFFB0; // read clears
	localparam logic [15:0] off_update_id = 16'hFFB4;
	localparam logic [15:0] off_update_size = 16'hFFB8;
	localparam logic [15:0] off_timer0 = 16'hFFC4; // timer i at +4*i

	localparam logic [data_w-1:0] ms_ticks_reset = 32'd1000;

	// which word the read mux returns
	typedef enum logic [3:0] {sel_none, sel_slot_id, sel_bridgeaddr, sel_length,
		sel_offset, sel_status, sel_ms_ticks, sel_reset_out,
		sel_update_flag, sel_update_id, sel_update_size,
		sel_timer} read_sel_t;

	typedef struct packed {
		logic [data_w-1:0] addr;
		logic [data_w-1:0] wdata;
		logic wr; // any byte enable set
	} bus_req_t;

	typedef struct packed {
		logic [15:0] id;
		logic [data_w-1:0] bridgeaddr;
		logic [data_w-1:0] length;
		logic [data_w-1:0] slotoffset;
	} slot_cmd_t;

	typedef struct packed {
		logic ack; // bit 4 of status word
		logic done; // bit 3
		logic [2:0] err; // zero is ok
	} slot_status_t;

	typedef struct packed {
		slot_cmd_t cmd;
		logic update_flag;
		logic [15:0] update_id;
		logic [data_w-1:0] update_size;
		logic reset_out;
		logic [data_w-1:0] ms_ticks; // same word the timers see
	} slot_regs_t;

	typedef struct packed {
		logic valid; // high one cycle per access
		logic wr_id, wr_bridgeaddr, wr_length, wr_offset, wr_ctrl, wr_ms_ticks, wr_reset_out;
		logic [num_timers-1:0] timer_clear;
		logic flag_clear;
		read_sel_t sel;
		logic [timer_idx_w-1:0] timer_idx;
		logic [data_w-1:0] wdata;
	} decode_t;

endpackage

`default_nettype wire

/* hw/mcu_bus_decode.sv */
// MCU bus address decoder
`timescale 1ns/10ps
`default_nettype none

module mcu_bus_decode (
	input logic clk_sys,
	input logic reset_n,
	input logic cpu_req,
	input mcu_pkg::bus_req_t cpu_bus,
	output mcu_pkg::decode_t dec
);
	import mcu_pkg::*;

	logic ack_pend; // ack cycle, req still held
	logic accept;
	logic in_window;
	logic [15:0] off;
	decode_t nxt;

	// new access only when nothing in flight
	assign accept = cpu_req & ~dec.valid & ~ack_pend;
	assign in_window = (cpu_bus.addr[31:16] == periph_base);
	assign off = cpu_bus.addr[15:0];

	always_comb begin
		nxt = '0;
		nxt.valid = 1'b1;
		nxt.wdata = cpu_bus.wdata;
		nxt.sel = sel_none; // unmapped reads give zero
		if (in_window) begin
			if (cpu_bus.wr) begin
				case (off)
					off_slot_id: nxt.wr_id = 1'b1;
					off_slot_bridgeaddr: nxt.wr_bridgeaddr = 1'b1;
					off_slot_length: nxt.wr_length = 1'b1;
					off_slot_offset: nxt.wr_offset = 1'b1;
					off_slot_ctrl: nxt.wr_ctrl = 1'b1; // fires the target pulses
					off_ms_ticks: nxt.wr_ms_ticks = 1'b1;
					off_reset_out: nxt.wr_reset_out = 1'b1;
					default: ; // read-only or unmapped, write dropped
				endcase
			end else begin
				case (off)
					off_slot_id: nxt.sel = sel_slot_id;
					off_slot_bridgeaddr: nxt.sel = sel_bridgeaddr;
					off_slot_length: nxt.sel = sel_length;
					off_slot_offset: nxt.sel = sel_offset;
					off_slot_ctrl: nxt.sel = sel_status;
					off_ms_ticks: nxt.sel = sel_ms_ticks;
					off_reset_out: nxt.sel = sel_reset_out;
					off_update_flag: begin
						nxt.sel = sel_update_flag;
						nxt.flag_clear = 1'b1; // read acks the update
					end
					off_update_id: nxt.sel = sel_update_id;
					off_update_size: nxt.sel = sel_update_size;
					default: ;
				endcase
			end
			// timers sit in a row after off_timer0
			for (int i = 0; i < num_timers; i++) begin
				if (off == 16'(off_timer0 + 4 * i)) begin
					nxt.timer_idx = timer_idx_w'(i);
					if (cpu_bus.wr)
						nxt.timer_clear[i] = 1'b1; // any write clears
					else
						nxt.sel = sel_timer;
				end
			end
		end
	end

	// edge 1, everything zero unless a new access starts
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			dec <= '0;
			ack_pend <= 1'b0;
		end else begin
			dec <= accept ? nxt : '0;
			ack_pend <= dec.valid; // covers the ack cycle
		end
	end

	// one access in flight, never back to back
	a_dec_single: assert property (@(posedge clk_sys) disable iff (!reset_n)
		dec.valid |=> !dec.valid);

endmodule

`default_nettype wire

/* hw/ms_timer.sv */
// Millisecond timer
`timescale 1ns/10ps
`default_nettype none

module ms_timer (
	input logic clk_sys,
	input logic reset_n,
	input logic clear,
	input logic [mcu_pkg::data_w-1:0] ms_ticks,
	output logic [mcu_pkg::data_w-1:0] count
);
	import mcu_pkg::*;

	logic [presc_w-1:0] prescale; // cycles into the current ms
	logic ms_done;

	// wraps after ms_ticks+1 cycles
	assign ms_done = (data_w'(prescale) == ms_ticks);

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			prescale <= '0;
			count <= '0;
		end else if (clear) begin
			prescale <= '0; // restart mid-ms too
			count <= '0;
		end else if (ms_done) begin
			prescale <= '0;
			count <= count + 1'b1;
		end else begin
			prescale <= prescale + 1'b1;
		end
	end

	// at most one ms per cycle outside of a clear
	a_count_step: assert property (@(posedge clk_sys) disable iff (!reset_n)
		!clear |=> (data_w'(count - $past(count)) <= data_w'(1)));

endmodule

`default_nettype wire

/* hw/dataslot_regs.sv */
// Target dataslot registers
`timescale 1ns/10ps
`default_nettype none

module dataslot_regs (
	input logic clk_sys,
	input logic reset_n,
	input mcu_pkg::decode_t dec,
	input logic dataslot_update,
	input logic [15:0] dataslot_update_id,
	input logic [mcu_pkg::data_w-1:0] dataslot_update_size,
	output mcu_pkg::slot_cmd_t slot_cmd,
	output logic target_dataslot_read,
	output logic target_dataslot_write,
	output logic reset_out,
	output logic [mcu_pkg::data_w-1:0] ms_ticks,
	output mcu_pkg::slot_regs_t slot_view
);
	import mcu_pkg::*;

	logic update_flag; // set by the host, cleared by a cpu read
	logic [15:0] update_id;
	logic [data_w-1:0] update_size;

	// control state, effective at the ack edge
	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n) begin
			slot_cmd <= '0;
			ms_ticks <= ms_ticks_reset;
			reset_out <= 1'b0;
			target_dataslot_read <= 1'b0;
			target_dataslot_write <= 1'b0;
			update_flag <= 1'b0;
		end else begin
			// single-cycle command pulses
			target_dataslot_read <= dec.wr_ctrl & dec.wdata[0];
			target_dataslot_write <= dec.wr_ctrl & dec.wdata[1];
			if (dec.wr_id)
				slot_cmd.id <= dec.wdata[15:0]; // only 16 bits kept
			if (dec.wr_bridgeaddr)
				slot_cmd.bridgeaddr <= dec.wdata;
			if (dec.wr_length)
				slot_cmd.length <= dec.wdata;
			if (dec.wr_offset)
				slot_cmd.slotoffset <= dec.wdata;
			if (dec.wr_ms_ticks)
				ms_ticks <= dec.wdata;
			if (dec.wr_reset_out)
				reset_out <= dec.wdata[0];
			// set beats a clear in the same cycle
			if (dataslot_update)
				update_flag <= 1'b1;
			else if (dec.flag_clear)
				update_flag <= 1'b0;
		end
	end

	// captured with the update pulse
	always_ff @(posedge clk_sys) begin
		if (dataslot_update) begin
			update_id <= dataslot_update_id;
			update_size <= dataslot_update_size;
		end
	end

	assign slot_view = '{cmd: slot_cmd,
		update_flag: update_flag,
		update_id: update_id,
		update_size: update_size,
		reset_out: reset_out,
		ms_ticks: ms_ticks};

	// pulses never stretch
	a_read_pulse: assert property (@(posedge clk_sys) disable iff (!reset_n)
		target_dataslot_read |=> !target_dataslot_read);
	a_write_pulse: assert property (@(posedge clk_sys) disable iff (!reset_n)
		target_dataslot_write |=> !target_dataslot_write);

endmodule

`default_nettype wire

/* hw/mcu_read_mux.sv */
// MCU read data mux
`timescale 1ns/10ps
`default_nettype none

module mcu_read_mux (
	input logic clk_sys,
	input logic reset_n,
	input mcu_pkg::decode_t dec,
	input mcu_pkg::slot_regs_t slot_view,
	input mcu_pkg::slot_status_t slot_status,
	input logic [mcu_pkg::data_w-1:0] timer_count [mcu_pkg::num_timers],
	output logic cpu_ack,
	output logic [mcu_pkg::data_w-1:0] cpu_rdata
);
	import mcu_pkg::*;

	logic [data_w-1:0] word; // selected before the ack edge

	always_comb begin
		case (dec.sel)
			sel_slot_id: word = data_w'(slot_view.cmd.id);
			sel_bridgeaddr: word = slot_view.cmd.bridgeaddr;
			sel_length: word = slot_view.cmd.length;
			sel_offset: word = slot_view.cmd.slotoffset;
			// ack bit 4, done bit 3, err 2:0
			sel_status: word = data_w'(slot_status);
			sel_ms_ticks: word = slot_view.ms_ticks;
			sel_reset_out: word = data_w'(slot_view.reset_out);
			sel_update_flag: word = data_w'(slot_view.update_flag); // old value, clear lands later
			sel_update_id: word = data_w'(slot_view.update_id);
			sel_update_size: word = slot_view.update_size;
			sel_timer: word = timer_count[dec.timer_idx];
			default: word = '0; // writes and unmapped
		endcase
	end

	always_ff @(posedge clk_sys or negedge reset_n) begin
		if (!reset_n)
			cpu_ack <= 1'b0;
		else
			cpu_ack <= dec.valid; // edge 2, one cycle
	end

	always_ff @(posedge clk_sys) begin
		if (dec.valid)
			cpu_rdata <= word;
	end

endmodule

`default_nettype wire

/* hw/mcu_periph_top.sv */
// MCU peripheral block top
`timescale 1ns/10ps
`default_nettype none

module mcu_periph_top (
	input logic clk_sys,
	input logic reset_n,
	input logic cpu_req,
	input mcu_pkg::bus_req_t cpu_bus,
	output logic cpu_ack,
	output logic [mcu_pkg::data_w-1:0] cpu_rdata,
	output mcu_pkg::slot_cmd_t slot_cmd,
	output logic target_dataslot_read,
	output logic target_dataslot_write,
	input mcu_pkg::slot_status_t slot_status,
	input logic dataslot_update,
	input logic [15:0] dataslot_update_id,
	input logic [mcu_pkg::data_w-1:0] dataslot_update_size,
	output logic reset_out
);
	import mcu_pkg::*;

	decode_t dec; // one-cycle decoded access
	slot_regs_t slot_view;
	logic [data_w-1:0] ms_ticks; // shared by all timers
	logic [data_w-1:0] timer_count [num_timers];

	mcu_bus_decode u_decode (
		.clk_sys(clk_sys),
		.reset_n(reset_n),
		.cpu_req(cpu_req),
		.cpu_bus(cpu_bus),
		.dec(dec)
	);

	// one timer per slot, own clear each
	for (genvar g = 0; g < num_timers; g++) begin : g_timer
		ms_timer u_timer (
			.clk_sys(clk_sys),
			.reset_n(reset_n),
			.clear(dec.timer_clear[g]),
			.ms_ticks(ms_ticks),
			.count(timer_count[g])
		);
	end

	dataslot_regs u_regs (
		.clk_sys(clk_sys),
		.reset_n(reset_n),
		.dec(dec),
		.dataslot_update(dataslot_update),
		.dataslot_update_id(dataslot_update_id),
		.dataslot_update_size(dataslot_update_size),
		.slot_cmd(slot_cmd),
		.target_dataslot_read(target_dataslot_read),
		.target_dataslot_write(target_dataslot_write),
		.reset_out(reset_out),
		.ms_ticks(ms_ticks),
		.slot_view(slot_view)
	);

	mcu_read_mux u_rdmux (
		.clk_sys(clk_sys),
		.reset_n(reset_n),
		.dec(dec),
		.slot_view(slot_view),
		.slot_status(slot_status),
		.timer_count(timer_count),
		.cpu_ack(cpu_ack),
		.cpu_rdata(cpu_rdata)
	);

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
	output logic clk_sys,
	output logic reset_n
);

	initial begin
		clk_sys = 1'b0;
		reset_n = 1'b0; // low for three cycles
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		reset_n = 1'b1; // released away from the active edge
	end

	always #2 clk_sys = ~clk_sys; // 4 ns period

endmodule

`default_nettype wire

/* verif/mcu_periph_tb.sv */
// MCU peripheral testbench
`timescale 1ns/10ps
`default_nettype none

module mcu_periph_tb;
	import mcu_pkg::*;

	logic clk_sys, reset_n;
	logic cpu_req;
	bus_req_t cpu_bus;
	logic cpu_ack;
	logic [data_w-1:0] cpu_rdata;
	slot_cmd_t slot_cmd;
	logic target_dataslot_read, target_dataslot_write;
	slot_status_t slot_status;
	logic dataslot_update;
	logic [15:0] dataslot_update_id;
	logic [data_w-1:0] dataslot_update_size;
	logic reset_out;

	// reference model, pend_* become exp_* on the ack edge
	slot_cmd_t exp_cmd, pend_cmd;
	logic exp_reset_out, pend_reset_out;
	logic [data_w-1:0] exp_ms_ticks, pend_ms_ticks;
	logic chk_rdata; // read data checked on this ack
	logic [data_w-1:0] rdata_lo, rdata_hi;
	logic exp_rd_pulse, exp_wr_pulse;
	integer seed;

	tb_clock_gen u_clk (.clk_sys(clk_sys), .reset_n(reset_n));

	mcu_periph_top DUT (
		.clk_sys(clk_sys), .reset_n(reset_n),
		.cpu_req(cpu_req), .cpu_bus(cpu_bus),
		.cpu_ack(cpu_ack), .cpu_rdata(cpu_rdata),
		.slot_cmd(slot_cmd),
		.target_dataslot_read(target_dataslot_read),
		.target_dataslot_write(target_dataslot_write),
		.slot_status(slot_status),
		.dataslot_update(dataslot_update),
		.dataslot_update_id(dataslot_update_id),
		.dataslot_update_size(dataslot_update_size),
		.reset_out(reset_out)
	);

	task automatic report_and_stop(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	function automatic logic [data_w-1:0] window_addr(input logic [15:0] off);
		return {periph_base, off};
	endfunction

	// one access, req held through the ack cycle, then one idle cycle
	task automatic bus_access(input logic [data_w-1:0] addr, input logic [data_w-1:0] wdata,
			input logic wr, output logic [data_w-1:0] rdata);
		cpu_bus.addr = addr;
		cpu_bus.wdata = wdata;
		cpu_bus.wr = wr;
		cpu_req = 1'b1;
		do begin
			@(negedge clk_sys);
		end while (!cpu_ack);
		rdata = cpu_rdata;
		exp_cmd = pend_cmd; // side effects seen from the ack edge on
		exp_reset_out = pend_reset_out;
		exp_ms_ticks = pend_ms_ticks;
		@(negedge clk_sys);
		cpu_req = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic write_reg(input logic [data_w-1:0] addr, input logic [data_w-1:0] wdata);
		logic [data_w-1:0] ignored;
		chk_rdata = 1'b0;
		bus_access(addr, wdata, 1'b1, ignored);
	endtask

	task automatic read_range(input logic [data_w-1:0] addr, input logic [data_w-1:0] lo,
			input logic [data_w-1:0] hi, output logic [data_w-1:0] rdata);
		rdata_lo = lo;
		rdata_hi = hi;
		chk_rdata = 1'b1;
		bus_access(addr, '0, 1'b0, rdata);
		chk_rdata = 1'b0;
	endtask

	task automatic read_expect(input logic [data_w-1:0] addr, input logic [data_w-1:0] value);
		logic [data_w-1:0] rdata;
		read_range(addr, value, value, rdata);
	endtask

	// ctrl write, bits 1:0 pick the pulses
	task automatic write_cmd(input logic [1:0] pulses);
		logic [data_w-1:0] w;
		w = $random(seed);
		exp_rd_pulse = pulses[0];
		exp_wr_pulse = pulses[1];
		write_reg(window_addr(off_slot_ctrl), {w[31:2], pulses});
		exp_rd_pulse = 1'b0;
		exp_wr_pulse = 1'b0;
	endtask

	task automatic pulse_update(input logic [15:0] id, input logic [data_w-1:0] size);
		dataslot_update_id = id;
		dataslot_update_size = size;
		dataslot_update = 1'b1; // single cycle
		@(negedge clk_sys);
		dataslot_update = 1'b0;
	endtask

	a_ack_timing: assert property (@(posedge clk_sys) disable iff (!reset_n)
		cpu_ack == ($past(cpu_req, 2) && !$past(cpu_req, 3)))
		else report_and_stop($sformatf(
			"cpu_ack at %0t is not one cycle, two cycles after cpu_req rose", $time));
	a_rdata: assert property (@(posedge clk_sys) disable iff (!reset_n)
		cpu_ack && chk_rdata |-> cpu_rdata >= rdata_lo && cpu_rdata <= rdata_hi)
		else report_and_stop($sformatf("Mismatch at %0t: cpu_rdata = 0x%h, expected 0x%h to 0x%h",
			$time, cpu_rdata, rdata_lo, rdata_hi));
	a_rd_pulse: assert property (@(posedge clk_sys) disable iff (!reset_n)
		target_dataslot_read == (cpu_ack && exp_rd_pulse))
		else report_and_stop($sformatf("Mismatch at %0t: target_dataslot_read = %b, expected %b",
			$time, target_dataslot_read, cpu_ack && exp_rd_pulse));
	a_wr_pulse: assert property (@(posedge clk_sys) disable iff (!reset_n)
		target_dataslot_write == (cpu_ack && exp_wr_pulse))
		else report_and_stop($sformatf("Mismatch at %0t: target_dataslot_write = %b, expected %b",
			$time, target_dataslot_write, cpu_ack && exp_wr_pulse));
	a_slot_cmd: assert property (@(posedge clk_sys) disable iff (!reset_n)
		slot_cmd == exp_cmd)
		else report_and_stop($sformatf("Mismatch at %0t: slot_cmd = 0x%h, expected 0x%h",
			$time, slot_cmd, exp_cmd));
	a_reset_out: assert property (@(posedge clk_sys) disable iff (!reset_n)
		reset_out == exp_reset_out)
		else report_and_stop($sformatf("Mismatch at %0t: reset_out = %b, expected %b",
			$time, reset_out, exp_reset_out));
	a_ms_ticks: assert property (@(posedge clk_sys) disable iff (!reset_n)
		DUT.u_regs.ms_ticks == exp_ms_ticks) // register feeding the timers
		else report_and_stop($sformatf("Mismatch at %0t: ms_ticks = 0x%h, expected 0x%h",
			$time, DUT.u_regs.ms_ticks, exp_ms_ticks));

	initial begin : watchdog
		int budget;
		budget = (64 * 4 + 18 + 240 + 8) * 4 * 2; // accesses plus timer waits, doubled
		#(budget);
		report_and_stop("Watchdog expired before the tests finished");
	end

	initial begin : stimulus
		logic [data_w-1:0] w, size, t0_val, t1_val;
		logic [15:0] id;
		int t_ms, n_wait;
		seed = 97288;
		cpu_req = 1'b0;
		cpu_bus = '0;
		slot_status = '0;
		dataslot_update = 1'b0;
		dataslot_update_id = '0;
		dataslot_update_size = '0;
		chk_rdata = 1'b0;
		rdata_lo = '0;
		rdata_hi = '0;
		exp_rd_pulse = 1'b0;
		exp_wr_pulse = 1'b0;
		exp_cmd = '0;
		exp_reset_out = 1'b0;
		exp_ms_ticks = ms_ticks_reset;
		pend_cmd = exp_cmd;
		pend_reset_out = exp_reset_out;
		pend_ms_ticks = exp_ms_ticks;
		@(posedge reset_n);
		@(negedge clk_sys);

		// reset values
		read_expect(window_addr(off_slot_id), '0);
		read_expect(window_addr(off_slot_bridgeaddr), '0);
		read_expect(window_addr(off_slot_length), '0);
		read_expect(window_addr(off_slot_offset), '0);
		read_expect(window_addr(off_reset_out), '0);
		read_expect(window_addr(off_update_flag), '0);
		read_expect(window_addr(off_ms_ticks), ms_ticks_reset);
		w = $random(seed);
		slot_status = slot_status_t'(w[4:0]);
		read_expect(window_addr(off_slot_ctrl), {27'b0, w[4:0]}); // status word

		// holes in the window and outside it
		read_expect(window_addr(16'hFF00), '0);
		read_expect(window_addr(16'hFFCC), '0); // past the last timer
		read_expect(32'h1234_FF84, '0);
		write_reg(32'h0000_FF80, $random(seed)); // must not reach slot id

		repeat (3) begin
			w = $random(seed);
			pend_cmd.id = w[15:0];
			write_reg(window_addr(off_slot_id), w);
			read_expect(window_addr(off_slot_id), {16'b0, w[15:0]});
			w = $random(seed);
			pend_cmd.bridgeaddr = w;
			write_reg(window_addr(off_slot_bridgeaddr), w);
			read_expect(window_addr(off_slot_bridgeaddr), w);
			w = $random(seed);
			pend_cmd.length = w;
			write_reg(window_addr(off_slot_length), w);
			read_expect(window_addr(off_slot_length), w);
			w = $random(seed);
			pend_cmd.slotoffset = w;
			write_reg(window_addr(off_slot_offset), w);
			read_expect(window_addr(off_slot_offset), w);
			w = $random(seed);
			pend_reset_out = w[0];
			write_reg(window_addr(off_reset_out), w);
			read_expect(window_addr(off_reset_out), {31'b0, w[0]});
			w = $random(seed);
			pend_ms_ticks = w; // seen at the register
			write_reg(window_addr(off_ms_ticks), w);
			read_expect(window_addr(off_ms_ticks), w);
		end

		// command pulses and status
		write_cmd(2'd1);
		write_cmd(2'd2);
		write_cmd(2'd3);
		write_cmd(2'd0);
		w = $random(seed);
		slot_status = slot_status_t'(w[4:0]);
		read_expect(window_addr(off_slot_ctrl), {27'b0, w[4:0]});

		// update flag, read clears it
		w = $random(seed);
		id = w[15:0];
		size = $random(seed);
		pulse_update(id, size);
		read_expect(window_addr(off_update_flag), 32'd1);
		read_expect(window_addr(off_update_flag), '0);
		read_expect(window_addr(off_update_id), {16'b0, id});
		read_expect(window_addr(off_update_size), size);

		// timers, short ms of t_ms+1 cycles
		t_ms = 2 + int'($unsigned($random(seed)) % 4);
		n_wait = 40 * (t_ms + 1);
		pend_ms_ticks = data_w'(t_ms);
		write_reg(window_addr(off_ms_ticks), data_w'(t_ms));
		write_reg(window_addr(off_timer0 + 16'd4), $random(seed)); // timer 1 starts first
		repeat (3 * (t_ms + 1)) @(negedge clk_sys);
		write_reg(window_addr(off_timer0), $random(seed));
		repeat (n_wait) @(negedge clk_sys);
		read_range(window_addr(off_timer0), data_w'(n_wait / (t_ms + 1) - 1),
			data_w'(n_wait / (t_ms + 1) + 1), t0_val);
		read_range(window_addr(off_timer0 + 16'd4), t0_val, '1, t1_val);

		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
hw/mcu_pkg.sv
hw/mcu_bus_decode.sv
hw/ms_timer.sv
hw/dataslot_regs.sv
hw/mcu_read_mux.sv
hw/mcu_periph_top.sv
verif/tb_clock_gen.sv
verif/mcu_periph_tb.sv

/* Makefile */
SRCS := $(shell cat vlog.f)
BIN := obj_dir/Vmcu_periph_tb

.PHONY: all run clean

all: run

$(BIN): vlog.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module mcu_periph_tb -f vlog.f -o Vmcu_periph_tb

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
